// ==== frame_generator.f ====
+incdir+include
src/frame_gen_pkg.sv
src/frame_ctl_if.sv
src/frame_cfg_regs.sv
src/cgmii_sequencer.sv
src/payload_lfsr.sv
src/block_composer.sv
src/frame_generator.sv
dv/tb_clock_gen.sv
dv/frame_generator_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= frame_generator_tb
RTL_TOP    ?= frame_generator
FILELIST   ?= frame_generator.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/frame_generator_tb.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module frame_generator_tb;

	localparam logic [31:0] SEED       = 32'h1717e38a;
	// x^64 + x^63 + x^61 + x^60 + 1
	localparam logic [63:0] POLY_TAPS  = 64'hB000_0000_0000_0001;
	localparam int          WAIT_LIMIT = 500;

	logic           clock;
	logic           rst;
	logic           enable;
	logic           cfg_we;
	logic [1:0]     cfg_addr;
	logic [7:0]     cfg_wdata;
	logic [63:0]    tx_data;
	logic [7:0]     tx_ctrl;
	logic           valid;

	// reference model state holds the next word to issue
	frame_gen_pkg::tx_state_e   m_state;
	logic                       m_abort;
	logic [63:0]                m_lfsr;
	int                         m_cnt;
	int                         len_data;
	int                         len_term;
	int                         cfg_ndata;
	int                         cfg_nidle;
	int                         cfg_nterm;
	logic                       exp_valid;
	logic [63:0]                exp_data;
	logic [7:0]                 exp_ctrl;
	int                         n_frames = 0;
	int                         n_errors = 0;
	int                         n_empty = 0;
	int                         n_hold = 0;

	tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(5)) clock_gen
	(
		.o_clock (clock),
		.o_rst   (rst)
	);

	frame_generator UUT
	(
		.i_clock     (clock),
		.i_rst       (rst),
		.i_enable    (enable),
		.i_cfg_we    (cfg_we),
		.i_cfg_addr  (cfg_addr),
		.i_cfg_wdata (cfg_wdata),
		.o_tx_data   (tx_data),
		.o_tx_ctrl   (tx_ctrl),
		.o_valid     (valid)
	);

	task fail_run(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [63:0] lfsr_step(input logic [63:0] x);
		return {x[62:0], 1'b0} ^ (x[63] ? POLY_TAPS : 64'h0);
	endfunction

	// lane 0 is the top byte
	function automatic logic [63:0] term_word(input logic [63:0] payload, input int n);
		logic [63:0] w;
		for (int i = 0; i < 8; i++)
		begin
			if (i < n)
				w[63-8*i -: 8] = payload[63-8*i -: 8];
			else if (i == n)
				w[63-8*i -: 8] = `FG_TERM_CHAR;
			else
				w[63-8*i -: 8] = `FG_IDLE_CHAR;
		end
		return w;
	endfunction

	task put_word(input logic [63:0] d, input logic [7:0] c);
		exp_data <= d;
		exp_ctrl <= c;
	endtask

	// lengths are taken from the config at each frame start
	task start_frame();
		m_state  = frame_gen_pkg::IDLE;
		m_abort  = 1'b0;
		m_cnt    = (cfg_nidle == 0) ? 1 : cfg_nidle;
		len_data = cfg_ndata;
		len_term = cfg_nterm;
	endtask

	task issue_word();
		if (m_abort)
		begin
			put_word(`FG_ERROR_BLOCK, `FG_CTRL_IDLE);
			n_errors++;
			start_frame();
		end
		else
		begin
			case (m_state)
				frame_gen_pkg::INIT:
				begin
					put_word(`FG_SEQ_BLOCK, `FG_CTRL_ORD);
					start_frame();
				end
				frame_gen_pkg::IDLE:
				begin
					put_word({8{`FG_IDLE_CHAR}}, `FG_CTRL_IDLE);
					m_cnt--;
					if (m_cnt == 0)
						m_state = frame_gen_pkg::START;
				end
				frame_gen_pkg::START:
				begin
					put_word({`FG_START_CHAR, m_lfsr[55:0]}, `FG_CTRL_START);
					m_lfsr = lfsr_step(m_lfsr);
					m_cnt = len_data;
					m_state = (len_data == 0) ? frame_gen_pkg::TERM : frame_gen_pkg::DATA;
					if (len_data == 0)
						n_empty++;
				end
				frame_gen_pkg::DATA:
				begin
					put_word(m_lfsr, `FG_CTRL_DATA);
					m_lfsr = lfsr_step(m_lfsr);
					m_cnt--;
					if (m_cnt == 0)
						m_state = frame_gen_pkg::TERM;
				end
				default:
				begin
					put_word(term_word(m_lfsr, len_term), 8'hFF >> len_term);
					if (len_term != 0)
						m_lfsr = lfsr_step(m_lfsr);
					n_frames++;
					start_frame();
				end
			endcase
		end
	endtask

	always @(posedge clock)
	begin
		if (rst)
		begin
			m_state   = frame_gen_pkg::INIT;
			m_abort   = 1'b0;
			m_lfsr    = `FG_LFSR_SEED;
			cfg_ndata = 4;
			cfg_nidle = 2;
			cfg_nterm = 3;
			exp_valid <= 1'b0;
		end
		else
		begin
			exp_valid <= enable;
			if (enable)
				issue_word();
			else if (m_state inside {frame_gen_pkg::START, frame_gen_pkg::DATA,
				frame_gen_pkg::TERM})
				m_abort = 1'b1;
			else
				n_hold++;
			// register writes land after this edge's word
			if (cfg_we && cfg_addr == `FG_CFG_ADDR_NDATA)
				cfg_ndata = int'(cfg_wdata);
			if (cfg_we && cfg_addr == `FG_CFG_ADDR_NIDLE)
				cfg_nidle = int'(cfg_wdata[4:0]);
			if (cfg_we && cfg_addr == `FG_CFG_ADDR_NTERM)
				cfg_nterm = int'(cfg_wdata[2:0]);
		end
	end

	a_quiet_in_reset: assert property (@(posedge clock) rst |-> (valid !== 1'b1))
		else fail_run($sformatf("** Error at %0t ns: valid word during reset", $time));
	a_valid_match: assert property (@(posedge clock) disable iff (rst) valid == exp_valid)
		else fail_run($sformatf("** Error at %0t ns: o_valid differs from model", $time));
	a_data_match: assert property (@(posedge clock) disable iff (rst)
		(valid && exp_valid) |-> tx_data == exp_data)
		else fail_run($sformatf("** Error at %0t ns: o_tx_data differs from model", $time));
	a_ctrl_match: assert property (@(posedge clock) disable iff (rst)
		(valid && exp_valid) |-> tx_ctrl == exp_ctrl)
		else fail_run($sformatf("** Error at %0t ns: o_tx_ctrl differs from model", $time));

	task wait_reset_release();
		int n;
		n = 0;
		while (rst)
		begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				fail_run("timeout: reset was never released");
		end
	endtask

	task wait_state(input frame_gen_pkg::tx_state_e target);
		int n;
		n = 0;
		while (m_state != target || m_abort)
		begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				fail_run($sformatf("timeout: the stream never reached %s", target.name()));
		end
	endtask

	task run_frames(input int count);
		int n;
		int target;
		n = 0;
		target = n_frames + count;
		while (n_frames < target)
		begin
			@(negedge clock);
			n++;
			if (n > WAIT_LIMIT)
				fail_run("timeout: frames stopped completing");
		end
	endtask

	task write_cfg(input logic [1:0] addr, input logic [7:0] data);
		@(negedge clock);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(negedge clock);
		cfg_we    = 1'b0;
	endtask

	// called on a falling edge so the next rising edge sees enable low
	task hold_enable(input int cycles);
		enable = 1'b0;
		repeat (cycles)
			@(negedge clock);
		enable = 1'b1;
	endtask

	initial
	begin
		void'($urandom(SEED));
		enable    = 1'b1;
		cfg_we    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		wait_reset_release();
		run_frames(3);
		repeat (6)
		begin
			// writes start in the idle gap ahead of the start word
			wait_state(frame_gen_pkg::IDLE);
			write_cfg(`FG_CFG_ADDR_NDATA, 8'($urandom_range(12, 0)));
			write_cfg(`FG_CFG_ADDR_NIDLE, 8'($urandom_range(8, 1)));
			write_cfg(`FG_CFG_ADDR_NTERM, 8'($urandom_range(7, 0)));
			run_frames(2);
		end
		write_cfg(`FG_CFG_ADDR_NDATA, 8'd0);
		run_frames(2);
		write_cfg(`FG_CFG_ADDR_NDATA, 8'd6);
		run_frames(1);
		repeat (5)
		begin
			wait_state(frame_gen_pkg::IDLE);
			hold_enable($urandom_range(5, 1));
			run_frames(1);
		end
		// drops inside data words abort the frame
		repeat (3)
		begin
			wait_state(frame_gen_pkg::DATA);
			hold_enable($urandom_range(4, 1));
			run_frames(2);
		end
		if (n_errors != 3 || n_empty == 0 || n_hold == 0)
			fail_run("stimulus missed the abort, empty frame or hold cases");
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 5
)
(
	output logic o_clock,
	output logic o_rst
);

	initial
	begin
		o_clock = 1'b0;
		forever
			#HALF_PERIOD o_clock = ~o_clock;
	end

	// released on a falling edge, away from the active edge
	initial
	begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clock);
		@(negedge o_clock);
		o_rst = 1'b0;
	end

endmodule

// ==== src/frame_generator.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module frame_generator
(
	input  logic                        i_clock,
	input  logic                        i_rst,
	input  logic                        i_enable,
	input  logic                        i_cfg_we,
	input  logic [`FG_NB_CFG_ADDR-1:0]  i_cfg_addr,
	input  logic [`FG_NB_CFG_DATA-1:0]  i_cfg_wdata,
	output logic [`FG_NB_DATA-1:0]      o_tx_data,
	output logic [`FG_NB_CTRL-1:0]      o_tx_ctrl,
	output logic                        o_valid
);

	logic [`FG_NB_NDATA-1:0]    cfg_ndata;
	logic [`FG_NB_NIDLE-1:0]    cfg_nidle;
	logic [`FG_NB_NTERM-1:0]    cfg_nterm;
	logic [`FG_NB_DATA-1:0]     payload;

	frame_ctl_if u_ctl ();

	frame_cfg_regs u_cfg_regs
	(
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_ndata     (cfg_ndata),
		.o_nidle     (cfg_nidle),
		.o_nterm     (cfg_nterm)
	);

	cgmii_sequencer u_sequencer
	(
		.i_clock  (i_clock),
		.i_rst    (i_rst),
		.i_enable (i_enable),
		.i_ndata  (cfg_ndata),
		.i_nidle  (cfg_nidle),
		.i_nterm  (cfg_nterm),
		.ctl      (u_ctl)
	);

	// steps on every word that consumes payload
	payload_lfsr u_lfsr
	(
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_advance (u_ctl.advance),
		.o_word    (payload)
	);

	block_composer u_composer
	(
		.i_clock   (i_clock),
		.i_rst     (i_rst),
		.i_payload (payload),
		.ctl       (u_ctl),
		.o_tx_data (o_tx_data),
		.o_tx_ctrl (o_tx_ctrl),
		.o_valid   (o_valid)
	);

endmodule

// ==== src/block_composer.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module block_composer
(
	input  logic                        i_clock,
	input  logic                        i_rst,
	input  frame_gen_pkg::lane_word_u   i_payload,
	frame_ctl_if.comp                   ctl,
	output logic [`FG_NB_DATA-1:0]      o_tx_data,
	output logic [`FG_NB_CTRL-1:0]      o_tx_ctrl,
	output logic                        o_valid
);

	frame_gen_pkg::lane_word_u  start_w;
	frame_gen_pkg::lane_word_u  term_w;
	frame_gen_pkg::tx_word_s    word_d;
	frame_gen_pkg::tx_word_s    word_q;
	logic                       valid_q;

	// start char takes lane 0, payload lanes 1 to 7 follow
	always_comb
	begin
		start_w         = i_payload;
		start_w.lane[0] = `FG_START_CHAR;
	end

	// nterm payload lanes, then terminate, then idle fill
	always_comb
	begin
		for (int i = 0; i < `FG_NB_CTRL; i++)
		begin
			if (i < int'(ctl.nterm))
				term_w.lane[i] = i_payload.lane[i];
			else if (i == int'(ctl.nterm))
				term_w.lane[i] = `FG_TERM_CHAR;
			else
				term_w.lane[i] = `FG_IDLE_CHAR;
		end
	end

	always_comb
	begin
		word_d.data = `FG_IDLE_BLOCK;
		word_d.ctrl = `FG_CTRL_IDLE;
		case (ctl.state)
			frame_gen_pkg::INIT:
			begin
				word_d.data = `FG_SEQ_BLOCK;
				word_d.ctrl = `FG_CTRL_ORD;
			end
			frame_gen_pkg::START:
			begin
				word_d.data = start_w.raw;
				word_d.ctrl = `FG_CTRL_START;
			end
			frame_gen_pkg::DATA:
			begin
				word_d.data = i_payload.raw;
				word_d.ctrl = `FG_CTRL_DATA;
			end
			frame_gen_pkg::TERM:
			begin
				word_d.data = term_w.raw;
				word_d.ctrl = `FG_CTRL_IDLE >> ctl.nterm;
			end
			frame_gen_pkg::ERROR:
			begin
				word_d.data = `FG_ERROR_BLOCK;
				word_d.ctrl = `FG_CTRL_IDLE;
			end
			default:
			begin
				word_d.data = `FG_IDLE_BLOCK;
				word_d.ctrl = `FG_CTRL_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			word_q  <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= ctl.valid;
			// last word stays on the bus while disabled
			if (ctl.valid)
				word_q <= word_d;
		end
	end

	assign o_tx_data = word_q.data;
	assign o_tx_ctrl = word_q.ctrl;
	assign o_valid   = valid_q;

endmodule

// ==== src/payload_lfsr.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module payload_lfsr
(
	input  logic                    i_clock,
	input  logic                    i_rst,
	input  logic                    i_advance,
	output logic [`FG_NB_DATA-1:0]  o_word
);

	logic [`FG_NB_DATA-1:0] lfsr_q;
	logic [`FG_NB_DATA-1:0] lfsr_next;

	// galois step, feedback from the top bit
	assign lfsr_next = {lfsr_q[`FG_NB_DATA-2:0], 1'b0} ^
		(lfsr_q[`FG_NB_DATA-1] ? `FG_LFSR_TAPS : '0);

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
			lfsr_q <= `FG_LFSR_SEED;
		else if (i_advance)
			lfsr_q <= lfsr_next;
	end

	assign o_word = lfsr_q;

endmodule

// ==== src/cgmii_sequencer.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module cgmii_sequencer
(
	input  logic                        i_clock,
	input  logic                        i_rst,
	input  logic                        i_enable,
	input  logic [`FG_NB_NDATA-1:0]     i_ndata,
	input  logic [`FG_NB_NIDLE-1:0]     i_nidle,
	input  logic [`FG_NB_NTERM-1:0]     i_nterm,
	frame_ctl_if.seq                    ctl
);

	frame_gen_pkg::tx_state_e   state_q;
	logic                       abort_q;
	logic [`FG_NB_NDATA-1:0]    cnt_q;
	logic [`FG_NB_NDATA-1:0]    ndata_q;
	logic [`FG_NB_NTERM-1:0]    nterm_q;
	logic [`FG_NB_NDATA-1:0]    idle_len;
	logic                       in_frame;
	logic                       load_frame;

	// zero idle length still gives one idle word
	assign idle_len = (i_nidle == '0) ? `FG_NB_NDATA'(1) : `FG_NB_NDATA'(i_nidle);

	assign in_frame = (state_q == frame_gen_pkg::START) ||
		(state_q == frame_gen_pkg::DATA) || (state_q == frame_gen_pkg::TERM);

	// a new frame begins with its idle gap
	assign load_frame = i_enable && (abort_q || (state_q == frame_gen_pkg::INIT) ||
		(state_q == frame_gen_pkg::TERM));

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			state_q <= frame_gen_pkg::INIT;
			abort_q <= 1'b0;
			cnt_q   <= '0;
		end
		else if (!i_enable)
		begin
			if (in_frame)
				abort_q <= 1'b1;
		end
		else if (load_frame)
		begin
			state_q <= frame_gen_pkg::IDLE;
			abort_q <= 1'b0;
			cnt_q   <= idle_len;
		end
		else
		begin
			case (state_q)
				frame_gen_pkg::IDLE:
				begin
					if (cnt_q == `FG_NB_NDATA'(1))
						state_q <= frame_gen_pkg::START;
					else
						cnt_q <= cnt_q - 1'b1;
				end
				frame_gen_pkg::START:
				begin
					if (ndata_q == '0)
						state_q <= frame_gen_pkg::TERM;
					else
					begin
						state_q <= frame_gen_pkg::DATA;
						cnt_q   <= ndata_q;
					end
				end
				frame_gen_pkg::DATA:
				begin
					if (cnt_q == `FG_NB_NDATA'(1))
						state_q <= frame_gen_pkg::TERM;
					else
						cnt_q <= cnt_q - 1'b1;
				end
				default:
					state_q <= frame_gen_pkg::INIT;
			endcase
		end
	end

	// lengths held for the whole frame
	always_ff @(posedge i_clock)
	begin
		if (load_frame)
		begin
			ndata_q <= i_ndata;
			nterm_q <= i_nterm;
		end
	end

	assign ctl.state   = abort_q ? frame_gen_pkg::ERROR : state_q;
	assign ctl.valid   = i_enable;
	assign ctl.nterm   = nterm_q;
	assign ctl.advance = i_enable && !abort_q && ((state_q == frame_gen_pkg::START) ||
		(state_q == frame_gen_pkg::DATA) ||
		((state_q == frame_gen_pkg::TERM) && (nterm_q != '0)));

endmodule

// ==== src/frame_cfg_regs.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

module frame_cfg_regs
(
	input  logic                        i_clock,
	input  logic                        i_rst,
	input  logic                        i_cfg_we,
	input  logic [`FG_NB_CFG_ADDR-1:0]  i_cfg_addr,
	input  logic [`FG_NB_CFG_DATA-1:0]  i_cfg_wdata,
	output logic [`FG_NB_NDATA-1:0]     o_ndata,
	output logic [`FG_NB_NIDLE-1:0]     o_nidle,
	output logic [`FG_NB_NTERM-1:0]     o_nterm
);

	logic [`FG_NB_NDATA-1:0] ndata_q;
	logic [`FG_NB_NIDLE-1:0] nidle_q;
	logic [`FG_NB_NTERM-1:0] nterm_q;

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			ndata_q <= `FG_DEF_NDATA;
			nidle_q <= `FG_DEF_NIDLE;
			nterm_q <= `FG_DEF_NTERM;
		end
		else if (i_cfg_we)
		begin
			// upper bits of the write data are dropped
			case (i_cfg_addr)
				`FG_CFG_ADDR_NDATA:
					ndata_q <= i_cfg_wdata[`FG_NB_NDATA-1:0];
				`FG_CFG_ADDR_NIDLE:
					nidle_q <= i_cfg_wdata[`FG_NB_NIDLE-1:0];
				`FG_CFG_ADDR_NTERM:
					nterm_q <= i_cfg_wdata[`FG_NB_NTERM-1:0];
				default:
				begin
				end
			endcase
		end
	end

	assign o_ndata = ndata_q;
	assign o_nidle = nidle_q;
	assign o_nterm = nterm_q;

endmodule

// ==== src/frame_ctl_if.sv ====
`timescale 1ns/1ns
`include "frame_gen_settings.svh"

interface frame_ctl_if;

	frame_gen_pkg::tx_state_e   state;
	logic                       advance;
	logic [`FG_NB_NTERM-1:0]    nterm;
	logic                       valid;

	modport seq
	(
		output state,
		output advance,
		output nterm,
		output valid
	);

	// advance goes straight to the payload generator
	modport comp
	(
		input state,
		input nterm,
		input valid
	);

endinterface

// ==== src/frame_gen_pkg.sv ====
`include "frame_gen_settings.svh"

package frame_gen_pkg;

	// one-hot tx state, one word issued per state visit
	typedef enum logic [5:0]
	{
		INIT  = 6'b000001,
		IDLE  = 6'b000010,
		START = 6'b000100,
		DATA  = 6'b001000,
		TERM  = 6'b010000,
		ERROR = 6'b100000
	} tx_state_e;

	// payload word seen whole or per lane
	// lane 0 sits in the top byte
	typedef union packed
	{
		logic [`FG_NB_DATA-1:0]                     raw;
		logic [0:`FG_NB_CTRL-1][`FG_NB_BYTE-1:0]    lane;
	} lane_word_u;

	// data word plus its control mask
	typedef struct packed
	{
		logic [`FG_NB_DATA-1:0] data;
		logic [`FG_NB_CTRL-1:0] ctrl;
	} tx_word_s;

endpackage

// ==== include/frame_gen_settings.svh ====
`ifndef FRAME_GEN_SETTINGS_SVH
`define FRAME_GEN_SETTINGS_SVH

// word and field widths
`define FG_NB_DATA          64
`define FG_NB_CTRL          8
`define FG_NB_BYTE          8
`define FG_NB_NDATA         8
`define FG_NB_NIDLE         5
`define FG_NB_NTERM         3
`define FG_NB_CFG_ADDR      2
`define FG_NB_CFG_DATA      8

// cgmii characters
`define FG_IDLE_CHAR        8'h07
`define FG_START_CHAR       8'hFB
`define FG_TERM_CHAR        8'hFD
`define FG_IDLE_BLOCK       {8{`FG_IDLE_CHAR}}
`define FG_ERROR_BLOCK      64'hFEFEFEFEFEFEFEFE
// sequence ordered set, lane 0 carries the 9C marker
`define FG_SEQ_BLOCK        64'h9C68797300000000

// control masks, one bit per lane, lane 0 is the msb
`define FG_CTRL_ORD         8'h80
`define FG_CTRL_IDLE        8'hFF
`define FG_CTRL_START       8'h80
`define FG_CTRL_DATA        8'h00

// payload generator
`define FG_LFSR_SEED        64'hA5C31E0F5A3CE1F0
// x^64 + x^63 + x^61 + x^60 + 1
`define FG_LFSR_TAPS        64'hB000000000000001

// config register defaults and addresses
`define FG_DEF_NDATA        8'd4
`define FG_DEF_NIDLE        5'd2
`define FG_DEF_NTERM        3'd3
`define FG_CFG_ADDR_NDATA   2'd0
`define FG_CFG_ADDR_NIDLE   2'd1
`define FG_CFG_ADDR_NTERM   2'd2

`endif
